//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_noc_axi_master_adapter
FILELIST  ?= noc_axi.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only when the pass line shows up in the simulation output.
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -F -x "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- noc_axi.f
verilog/noc_axi_pkg.sv
verilog/noc_flit_demux.sv
verilog/noc_axi_write_engine.sv
verilog/noc_axi_read_engine.sv
verilog/noc_resp_arbiter.sv
verilog/noc_axi_master_adapter.sv
tests/tb_noc_axi_master_adapter.sv

//--- tests/tb_noc_axi_master_adapter.sv
`timescale 1ns/1ns

module tb_noc_axi_master_adapter
  import noc_axi_pkg::*;
;

  localparam int    CLK_PERIOD      = 4;
  localparam int    TEST_COUNT      = 6;
  localparam int    CYCLES_PER_TEST = 200;
  localparam int    REQ_WAIT        = 100; // cycles allowed for a request handshake.
  localparam int    RESP_WAIT       = 100; // cycles allowed for a response flit.
  localparam id_x_t MY_X            = 3'd2;
  localparam id_y_t MY_Y            = 3'd5;
  localparam resp_t OKAY            = 2'b00;
  localparam resp_t SLVERR          = 2'b10;

  typedef struct packed {
    pkt_type_t typ;
    id_x_t     src_x;
    id_y_t     src_y;
    id_x_t     dst_x;
    id_y_t     dst_y;
    tag_t      tag;
    data_t     data;
    resp_t     resp;
  } flit_s;

  logic      clk;
  logic      i_rst_n;
  logic      i_req_valid;
  logic      o_req_ready;
  pkt_type_t i_req_type;
  id_x_t     i_req_src_x;
  id_y_t     i_req_src_y;
  tag_t      i_req_tag;
  addr_t     i_req_addr;
  data_t     i_req_data;
  logic      o_flit_valid;
  logic      i_flit_ready;
  pkt_type_t o_flit_type;
  id_x_t     o_flit_src_x;
  id_y_t     o_flit_src_y;
  id_x_t     o_flit_dst_x;
  id_y_t     o_flit_dst_y;
  tag_t      o_flit_tag;
  data_t     o_flit_data;
  resp_t     o_flit_resp;
  logic      o_awvalid;
  logic      i_awready;
  addr_t     o_awaddr;
  logic      o_wvalid;
  logic      i_wready;
  data_t     o_wdata;
  strb_t     o_wstrb;
  logic      i_bvalid;
  logic      o_bready;
  resp_t     i_bresp;
  logic      o_arvalid;
  logic      i_arready;
  addr_t     o_araddr;
  logic      i_rvalid;
  logic      o_rready;
  data_t     i_rdata;
  resp_t     i_rresp;

  integer     seed = 32'h3d98;
  int         mismatches = 0;
  int         failures = 0;
  flit_s      rsp_q[$];       // every response flit taken from the dut.
  data_t      sb_mem [64];    // last value written per word.
  id_x_t      src_x_r;        // requester coordinates for the next request.
  id_y_t      src_y_r;
  logic [1:0] delay_tab [256]; // ready delays for the slave model.

  data_t      mem [64];
  logic [7:0] delay_idx;
  int         aw_wait;
  int         w_wait;
  int         b_wait;
  int         ar_wait;
  int         r_wait;
  bit         aw_got;
  bit         w_got;
  bit         b_fire;
  bit         ar_got;
  bit         r_fire;
  addr_t      wr_addr;
  data_t      wr_data;
  strb_t      wr_strb;        // strobes seen with the last write data.
  addr_t      rd_addr;

  noc_axi_master_adapter #(
    .ARB_ROUND_ROBIN (1'b0)
  ) uut (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_id_x       (MY_X),
    .i_id_y       (MY_Y),
    .i_req_valid  (i_req_valid),
    .o_req_ready  (o_req_ready),
    .i_req_type   (i_req_type),
    .i_req_src_x  (i_req_src_x),
    .i_req_src_y  (i_req_src_y),
    .i_req_tag    (i_req_tag),
    .i_req_addr   (i_req_addr),
    .i_req_data   (i_req_data),
    .o_flit_valid (o_flit_valid),
    .i_flit_ready (i_flit_ready),
    .o_flit_type  (o_flit_type),
    .o_flit_src_x (o_flit_src_x),
    .o_flit_src_y (o_flit_src_y),
    .o_flit_dst_x (o_flit_dst_x),
    .o_flit_dst_y (o_flit_dst_y),
    .o_flit_tag   (o_flit_tag),
    .o_flit_data  (o_flit_data),
    .o_flit_resp  (o_flit_resp),
    .o_awvalid    (o_awvalid),
    .i_awready    (i_awready),
    .o_awaddr     (o_awaddr),
    .o_wvalid     (o_wvalid),
    .i_wready     (i_wready),
    .o_wdata      (o_wdata),
    .o_wstrb      (o_wstrb),
    .i_bvalid     (i_bvalid),
    .o_bready     (o_bready),
    .i_bresp      (i_bresp),
    .o_arvalid    (o_arvalid),
    .i_arready    (i_arready),
    .o_araddr     (o_araddr),
    .i_rvalid     (i_rvalid),
    .o_rready     (o_rready),
    .i_rdata      (i_rdata),
    .i_rresp      (i_rresp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
    $display("error: watchdog expired before the tests finished");
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      mismatches++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_tag(input string name, input tag_t exp, input tag_t act);
    if (exp !== act) begin
      mismatches++;
      $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (exp !== act) begin
      mismatches++;
      $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_type(input string name, input pkt_type_t exp, input pkt_type_t act);
    if (exp !== act) begin
      mismatches++;
      $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_id(input string name, input id_x_t exp, input id_x_t act);
    if (exp !== act) begin
      mismatches++;
      $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_strb(input string name, input strb_t exp, input strb_t act);
    if (exp !== act) begin
      mismatches++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  function automatic resp_t slave_resp(input addr_t addr);
    return (addr >= 32'h100) ? SLVERR : OKAY; // no memory above 0x100.
  endfunction

  task automatic draw_delay(output int d);
    d = int'(delay_tab[delay_idx]);
    delay_idx = delay_idx + 8'd1;
  endtask

  // aw and w are accepted independently, b only after both.
  task automatic slave_write_step;
    i_awready = 1'b0;
    i_wready  = 1'b0;
    if (b_fire) begin // b was taken on the last rising edge.
      i_bvalid = 1'b0;
      b_fire   = 1'b0;
      aw_got   = 1'b0;
      w_got    = 1'b0;
      draw_delay(aw_wait);
      draw_delay(w_wait);
      draw_delay(b_wait);
    end else if (i_bvalid) begin
      b_fire = o_bready;
    end else if (aw_got && w_got) begin
      if (b_wait == 0) begin
        i_bvalid = 1'b1;
        i_bresp  = slave_resp(wr_addr);
        if (i_bresp == OKAY) begin
          mem[wr_addr[7:2]] = wr_data;
        end
        b_fire = o_bready;
      end else begin
        b_wait--;
      end
    end
    if (o_awvalid && !aw_got) begin
      if (aw_wait == 0) begin
        i_awready = 1'b1;
        aw_got    = 1'b1;
        wr_addr   = o_awaddr;
      end else begin
        aw_wait--;
      end
    end
    if (o_wvalid && !w_got) begin
      if (w_wait == 0) begin
        i_wready = 1'b1;
        w_got    = 1'b1;
        wr_data  = o_wdata;
        wr_strb  = o_wstrb;
      end else begin
        w_wait--;
      end
    end
  endtask

  task automatic slave_read_step;
    i_arready = 1'b0;
    if (r_fire) begin
      i_rvalid = 1'b0;
      r_fire   = 1'b0;
      ar_got   = 1'b0;
      draw_delay(ar_wait);
      draw_delay(r_wait);
    end else if (i_rvalid) begin
      r_fire = o_rready;
    end else if (ar_got) begin
      if (r_wait == 0) begin
        i_rvalid = 1'b1;
        i_rresp  = slave_resp(rd_addr);
        i_rdata  = (i_rresp == OKAY) ? mem[rd_addr[7:2]] : '0;
        r_fire   = o_rready;
      end else begin
        r_wait--;
      end
    end
    if (o_arvalid && !ar_got) begin
      if (ar_wait == 0) begin
        i_arready = 1'b1;
        ar_got    = 1'b1;
        rd_addr   = o_araddr;
      end else begin
        ar_wait--;
      end
    end
  endtask

  // axi slave, decides on every falling edge.
  initial begin
    int i;
    i_awready = 1'b0;
    i_wready  = 1'b0;
    i_bvalid  = 1'b0;
    i_bresp   = OKAY;
    i_arready = 1'b0;
    i_rvalid  = 1'b0;
    i_rdata   = '0;
    i_rresp   = OKAY;
    delay_idx = 8'd0;
    aw_got    = 1'b0;
    w_got     = 1'b0;
    b_fire    = 1'b0;
    ar_got    = 1'b0;
    r_fire    = 1'b0;
    for (i = 0; i < 64; i++) begin
      mem[i[5:0]] = 32'hC0DE_0000 | (i << 2); // byte address in the low bits.
    end
    @(posedge i_rst_n);
    draw_delay(aw_wait);
    draw_delay(w_wait);
    draw_delay(b_wait);
    draw_delay(ar_wait);
    draw_delay(r_wait);
    forever begin
      @(negedge clk);
      slave_write_step();
      slave_read_step();
    end
  end

  function automatic flit_s sample_flit();
    flit_s f;
    f.typ   = o_flit_type;
    f.src_x = o_flit_src_x;
    f.src_y = o_flit_src_y;
    f.dst_x = o_flit_dst_x;
    f.dst_y = o_flit_dst_y;
    f.tag   = o_flit_tag;
    f.data  = o_flit_data;
    f.resp  = o_flit_resp;
    return f;
  endfunction

  // records each flit that transfers on the next rising edge.
  initial begin
    forever begin
      @(negedge clk);
      #1;
      if (i_rst_n && o_flit_valid && i_flit_ready) begin
        rsp_q.push_back(sample_flit());
      end
    end
  end

  task automatic drive_req(input pkt_type_t typ, input tag_t tag, input addr_t addr,
                           input data_t data);
    i_req_valid = 1'b1;
    i_req_type  = typ;
    i_req_src_x = src_x_r;
    i_req_src_y = src_y_r;
    i_req_tag   = tag;
    i_req_addr  = addr;
    i_req_data  = data;
  endtask

  // called at a falling edge with the request already driven.
  task automatic wait_accept(input tag_t tag);
    int  waited;
    bit  done;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < REQ_WAIT) begin
      #1;
      done = o_req_ready;
      @(negedge clk);
      waited++;
    end
    i_req_valid = 1'b0;
    if (!done) begin
      failures++;
      $display("error at %0t: request with tag %0d was never accepted", $time, tag);
    end
  endtask

  task automatic send_req(input pkt_type_t typ, input tag_t tag, input addr_t addr,
                          input data_t data);
    @(negedge clk);
    drive_req(typ, tag, addr, data);
    wait_accept(tag);
  endtask

  task automatic wait_resp(input int count, output bit ok);
    int waited;
    waited = 0;
    while (rsp_q.size() < count && waited < RESP_WAIT) begin
      @(posedge clk);
      waited++;
    end
    ok = (rsp_q.size() >= count);
    if (!ok) begin
      failures++;
      $display("error at %0t: an expected response flit never arrived", $time);
    end
  endtask

  task automatic check_flit(input flit_s f, input pkt_type_t typ, input tag_t tag,
                            input resp_t resp, input data_t data, input bit with_data);
    check_type("o_flit_type", typ, f.typ);
    check_id("o_flit_src_x", MY_X, f.src_x);
    check_id("o_flit_src_y", MY_Y, f.src_y);
    check_id("o_flit_dst_x", src_x_r, f.dst_x); // back to the requester.
    check_id("o_flit_dst_y", src_y_r, f.dst_y);
    check_tag("o_flit_tag", tag, f.tag);
    check_resp("o_flit_resp", resp, f.resp);
    if (with_data) begin
      check_data("o_flit_data", data, f.data);
    end
  endtask

  task automatic do_write(input tag_t tag, input addr_t addr, input data_t data,
                          input resp_t exp_resp);
    int first;
    bit ok;
    first = rsp_q.size();
    send_req(PKT_WRITE, tag, addr, data);
    if (exp_resp == OKAY) begin
      sb_mem[addr[7:2]] = data;
    end
    wait_resp(first + 1, ok);
    if (ok) begin
      check_flit(rsp_q[first], PKT_WRITE_RESP, tag, exp_resp, '0, 1'b1);
      check_strb("o_wstrb", '1, wr_strb); // full-word writes.
    end
  endtask

  task automatic do_read(input tag_t tag, input addr_t addr, input resp_t exp_resp,
                         input data_t exp_data, input bit with_data);
    int first;
    bit ok;
    first = rsp_q.size();
    send_req(PKT_READ, tag, addr, '0);
    wait_resp(first + 1, ok);
    if (ok) begin
      check_flit(rsp_q[first], PKT_READ_RESP, tag, exp_resp, exp_data, with_data);
    end
  endtask

  task automatic test_write_read;
    do_write(4'd3, 32'h10, 32'hA5A5_0001, OKAY);
    do_read(4'd4, 32'h10, OKAY, 32'hA5A5_0001, 1'b1);
  endtask

  task automatic test_error_resp;
    do_write(4'd1, 32'h200, 32'h1111_2222, SLVERR);
    do_read(4'd2, 32'h200, SLVERR, '0, 1'b0);
  endtask

  task automatic test_backpressure;
    int first;
    int waited;
    bit ok;
    first  = rsp_q.size();
    waited = 0;
    @(negedge clk);
    i_flit_ready = 1'b0;
    send_req(PKT_WRITE, 4'd7, 32'h20, 32'h0BAD_F00D);
    sb_mem[8] = 32'h0BAD_F00D;
    while (!o_flit_valid && waited < RESP_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (!o_flit_valid) begin
      failures++;
      $display("error at %0t: write response never appeared under back-pressure", $time);
      i_flit_ready = 1'b1;
    end else begin
      drive_req(PKT_WRITE, 4'd8, 32'h24, 32'h0000_BEEF); // second write, held off.
      repeat (20) begin
        #1;
        if (!o_flit_valid) begin
          failures++;
          $display("error at %0t: o_flit_valid dropped while output stalled", $time);
        end
        if (o_req_ready) begin
          failures++;
          $display("error at %0t: second write accepted while output stalled", $time);
        end
        check_flit(sample_flit(), PKT_WRITE_RESP, 4'd7, OKAY, '0, 1'b1);
        @(negedge clk);
      end
      i_flit_ready = 1'b1;
      wait_accept(4'd8);
      sb_mem[9] = 32'h0000_BEEF;
      wait_resp(first + 2, ok);
      if (ok) begin
        check_flit(rsp_q[first], PKT_WRITE_RESP, 4'd7, OKAY, '0, 1'b1);
        check_flit(rsp_q[first + 1], PKT_WRITE_RESP, 4'd8, OKAY, '0, 1'b1);
      end
    end
  endtask

  task automatic test_concurrent;
    int    first;
    int    k;
    bit    ok;
    bit    seen_wr;
    bit    seen_rd;
    flit_s f;
    first   = rsp_q.size();
    seen_wr = 1'b0;
    seen_rd = 1'b0;
    send_req(PKT_WRITE, 4'd5, 32'h40, 32'h1357_9BDF);
    sb_mem[16] = 32'h1357_9BDF;
    send_req(PKT_READ, 4'd6, 32'h10, '0);
    wait_resp(first + 2, ok);
    repeat (20) @(posedge clk); // room for a stray third flit.
    if (rsp_q.size() != first + 2) begin
      failures++;
      $display("error at %0t: expected two responses, got %0d", $time, rsp_q.size() - first);
    end
    for (k = first; k < rsp_q.size(); k++) begin
      f = rsp_q[k];
      if (f.tag == 4'd5) begin
        seen_wr = 1'b1;
        check_flit(f, PKT_WRITE_RESP, 4'd5, OKAY, '0, 1'b1);
      end else if (f.tag == 4'd6) begin
        seen_rd = 1'b1;
        check_flit(f, PKT_READ_RESP, 4'd6, OKAY, sb_mem[4], 1'b1);
      end else begin
        failures++;
        $display("error at %0t: response with unexpected tag %0d", $time, f.tag);
      end
    end
    if (!seen_wr || !seen_rd) begin
      failures++;
      $display("error at %0t: write or read response missing with both engines busy", $time);
    end
  endtask

  task automatic test_unknown_type;
    int first;
    first = rsp_q.size();
    send_req(PKT_WRITE_RESP, 4'd9, 32'h30, 32'h5555_AAAA); // response type as a request.
    repeat (50) @(posedge clk);
    if (rsp_q.size() != first || o_flit_valid) begin
      failures++;
      $display("error at %0t: a response appeared for an unknown request type", $time);
    end
    do_read(4'd10, 32'h10, OKAY, sb_mem[4], 1'b1);
  endtask

  task automatic test_random_traffic;
    int    n;
    int    r;
    addr_t addr;
    data_t data;
    for (n = 0; n < 20; n++) begin
      r       = $random(seed);
      addr    = {24'd0, r[7:2], 2'b00}; // word inside the okay range.
      src_x_r = r[10:8];
      src_y_r = r[13:11];
      data    = $random(seed);
      do_write(n[3:0], addr, data, OKAY);
      do_read(n[3:0], addr, OKAY, sb_mem[addr[7:2]], 1'b1);
    end
  endtask

  initial begin
    int i;
    int r;
    i_rst_n      = 1'b0;
    i_req_valid  = 1'b0;
    i_req_type   = PKT_WRITE;
    i_req_src_x  = '0;
    i_req_src_y  = '0;
    i_req_tag    = '0;
    i_req_addr   = '0;
    i_req_data   = '0;
    i_flit_ready = 1'b1;
    src_x_r      = 3'd1;
    src_y_r      = 3'd4;
    for (i = 0; i < 256; i++) begin
      r = $random(seed);
      delay_tab[i[7:0]] = r[1:0]; // 0 to 3 cycles.
    end
    repeat (10) @(negedge clk);
    i_rst_n = 1'b1;
    repeat (2) @(negedge clk);
    test_write_read();
    test_error_resp();
    test_backpressure();
    test_concurrent();
    test_unknown_type();
    test_random_traffic();
    repeat (5) @(negedge clk);
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- verilog/noc_axi_master_adapter.sv
`timescale 1ns/1ns

module noc_axi_master_adapter
  import noc_axi_pkg::*;
#(
  parameter bit ARB_ROUND_ROBIN = 1'b0
)(
  input  logic      clk,
  input  logic      i_rst_n,
  input  id_x_t     i_id_x,
  input  id_y_t     i_id_y,
  input  logic      i_req_valid,
  output logic      o_req_ready,
  input  pkt_type_t i_req_type,
  input  id_x_t     i_req_src_x,
  input  id_y_t     i_req_src_y,
  input  tag_t      i_req_tag,
  input  addr_t     i_req_addr,
  input  data_t     i_req_data,
  output logic      o_flit_valid,
  input  logic      i_flit_ready,
  output pkt_type_t o_flit_type,
  output id_x_t     o_flit_src_x,
  output id_y_t     o_flit_src_y,
  output id_x_t     o_flit_dst_x,
  output id_y_t     o_flit_dst_y,
  output tag_t      o_flit_tag,
  output data_t     o_flit_data,
  output resp_t     o_flit_resp,
  output logic      o_awvalid,
  input  logic      i_awready,
  output addr_t     o_awaddr,
  output logic      o_wvalid,
  input  logic      i_wready,
  output data_t     o_wdata,
  output strb_t     o_wstrb,
  input  logic      i_bvalid,
  output logic      o_bready,
  input  resp_t     i_bresp,
  output logic      o_arvalid,
  input  logic      i_arready,
  output addr_t     o_araddr,
  input  logic      i_rvalid,
  output logic      o_rready,
  input  data_t     i_rdata,
  input  resp_t     i_rresp
);

  logic  wr_req_valid;
  logic  wr_req_ready;
  logic  rd_req_valid;
  logic  rd_req_ready;

  logic  wr_resp_valid;
  logic  wr_resp_ready;
  id_x_t wr_resp_dst_x;
  id_y_t wr_resp_dst_y;
  id_x_t wr_resp_src_x;
  id_y_t wr_resp_src_y;
  tag_t  wr_resp_tag;
  resp_t wr_resp_code;

  logic  rd_resp_valid;
  logic  rd_resp_ready;
  id_x_t rd_resp_dst_x;
  id_y_t rd_resp_dst_y;
  id_x_t rd_resp_src_x;
  id_y_t rd_resp_src_y;
  tag_t  rd_resp_tag;
  resp_t rd_resp_code;
  data_t rd_resp_data;

  noc_flit_demux u_demux (
    .i_req_valid (i_req_valid  ),
    .o_req_ready (o_req_ready  ),
    .i_req_type  (i_req_type   ),
    .i_wr_ready  (wr_req_ready ),
    .i_rd_ready  (rd_req_ready ),
    .o_wr_valid  (wr_req_valid ),
    .o_rd_valid  (rd_req_valid )
  );

  // request payload fans out to both engines.
  noc_axi_write_engine u_write_engine (
    .clk          (clk           ),
    .i_rst_n      (i_rst_n       ),
    .i_id_x       (i_id_x        ),
    .i_id_y       (i_id_y        ),
    .i_valid      (wr_req_valid  ),
    .o_ready      (wr_req_ready  ),
    .i_src_x      (i_req_src_x   ),
    .i_src_y      (i_req_src_y   ),
    .i_tag        (i_req_tag     ),
    .i_addr       (i_req_addr    ),
    .i_data       (i_req_data    ),
    .o_awvalid    (o_awvalid     ),
    .i_awready    (i_awready     ),
    .o_awaddr     (o_awaddr      ),
    .o_wvalid     (o_wvalid      ),
    .i_wready     (i_wready      ),
    .o_wdata      (o_wdata       ),
    .o_wstrb      (o_wstrb       ),
    .i_bvalid     (i_bvalid      ),
    .o_bready     (o_bready      ),
    .i_bresp      (i_bresp       ),
    .o_resp_valid (wr_resp_valid ),
    .i_resp_ready (wr_resp_ready ),
    .o_resp_dst_x (wr_resp_dst_x ),
    .o_resp_dst_y (wr_resp_dst_y ),
    .o_resp_src_x (wr_resp_src_x ),
    .o_resp_src_y (wr_resp_src_y ),
    .o_resp_tag   (wr_resp_tag   ),
    .o_resp_code  (wr_resp_code  )
  );

  noc_axi_read_engine u_read_engine (
    .clk          (clk           ),
    .i_rst_n      (i_rst_n       ),
    .i_id_x       (i_id_x        ),
    .i_id_y       (i_id_y        ),
    .i_valid      (rd_req_valid  ),
    .o_ready      (rd_req_ready  ),
    .i_src_x      (i_req_src_x   ),
    .i_src_y      (i_req_src_y   ),
    .i_tag        (i_req_tag     ),
    .i_addr       (i_req_addr    ),
    .o_arvalid    (o_arvalid     ),
    .i_arready    (i_arready     ),
    .o_araddr     (o_araddr      ),
    .i_rvalid     (i_rvalid      ),
    .o_rready     (o_rready      ),
    .i_rdata      (i_rdata       ),
    .i_rresp      (i_rresp       ),
    .o_resp_valid (rd_resp_valid ),
    .i_resp_ready (rd_resp_ready ),
    .o_resp_dst_x (rd_resp_dst_x ),
    .o_resp_dst_y (rd_resp_dst_y ),
    .o_resp_src_x (rd_resp_src_x ),
    .o_resp_src_y (rd_resp_src_y ),
    .o_resp_tag   (rd_resp_tag   ),
    .o_resp_code  (rd_resp_code  ),
    .o_resp_data  (rd_resp_data  )
  );

  noc_resp_arbiter #(
    .ARB_ROUND_ROBIN (ARB_ROUND_ROBIN )
  ) u_resp_arbiter (
    .clk          (clk           ),
    .i_rst_n      (i_rst_n       ),
    .i_wr_valid   (wr_resp_valid ),
    .o_wr_ready   (wr_resp_ready ),
    .i_wr_dst_x   (wr_resp_dst_x ),
    .i_wr_dst_y   (wr_resp_dst_y ),
    .i_wr_src_x   (wr_resp_src_x ),
    .i_wr_src_y   (wr_resp_src_y ),
    .i_wr_tag     (wr_resp_tag   ),
    .i_wr_resp    (wr_resp_code  ),
    .i_rd_valid   (rd_resp_valid ),
    .o_rd_ready   (rd_resp_ready ),
    .i_rd_dst_x   (rd_resp_dst_x ),
    .i_rd_dst_y   (rd_resp_dst_y ),
    .i_rd_src_x   (rd_resp_src_x ),
    .i_rd_src_y   (rd_resp_src_y ),
    .i_rd_tag     (rd_resp_tag   ),
    .i_rd_resp    (rd_resp_code  ),
    .i_rd_data    (rd_resp_data  ),
    .o_flit_valid (o_flit_valid  ),
    .i_flit_ready (i_flit_ready  ),
    .o_flit_type  (o_flit_type   ),
    .o_flit_src_x (o_flit_src_x  ),
    .o_flit_src_y (o_flit_src_y  ),
    .o_flit_dst_x (o_flit_dst_x  ),
    .o_flit_dst_y (o_flit_dst_y  ),
    .o_flit_tag   (o_flit_tag    ),
    .o_flit_data  (o_flit_data   ),
    .o_flit_resp  (o_flit_resp   )
  );

endmodule

//--- verilog/noc_axi_pkg.sv
package noc_axi_pkg;

  localparam int ADDR_W = 32;          // axi and flit address.
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;  // one strobe per byte.
  localparam int ID_X_W = 3;           // mesh column.
  localparam int ID_Y_W = 3;           // mesh row.
  localparam int TAG_W  = 4;           // requester transaction tag.
  localparam int TYPE_W = 2;
  localparam int RESP_W = 2;           // axi xresp encoding.

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ID_X_W-1:0] id_x_t;
  typedef logic [ID_Y_W-1:0] id_y_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [TYPE_W-1:0] pkt_type_t;
  typedef logic [RESP_W-1:0] resp_t;

  // requests use the low two codes, responses the high two.
  localparam pkt_type_t PKT_WRITE      = 2'd0;
  localparam pkt_type_t PKT_READ       = 2'd1;
  localparam pkt_type_t PKT_WRITE_RESP = 2'd2;
  localparam pkt_type_t PKT_READ_RESP  = 2'd3;

  // shared by the write and read engines.
  typedef enum logic [1:0] {
    IDLE, // waiting for a request flit.
    ADDR, // address (and write data) channels in flight.
    RESP, // waiting for b or r.
    SEND  // response flit offered to the arbiter.
  } engine_state_e;

endpackage

//--- verilog/noc_axi_read_engine.sv
`timescale 1ns/1ns

module noc_axi_read_engine
  import noc_axi_pkg::*;
(
  input  logic  clk,
  input  logic  i_rst_n,
  input  id_x_t i_id_x,
  input  id_y_t i_id_y,
  input  logic  i_valid,
  output logic  o_ready,
  input  id_x_t i_src_x,
  input  id_y_t i_src_y,
  input  tag_t  i_tag,
  input  addr_t i_addr,
  output logic  o_arvalid,
  input  logic  i_arready,
  output addr_t o_araddr,
  input  logic  i_rvalid,
  output logic  o_rready,
  input  data_t i_rdata,
  input  resp_t i_rresp,
  output logic  o_resp_valid,
  input  logic  i_resp_ready,
  output id_x_t o_resp_dst_x,
  output id_y_t o_resp_dst_y,
  output id_x_t o_resp_src_x,
  output id_y_t o_resp_src_y,
  output tag_t  o_resp_tag,
  output resp_t o_resp_code,
  output data_t o_resp_data
);

  engine_state_e state;
  addr_t         addr_q;
  id_x_t         src_x_q;
  id_y_t         src_y_q;
  tag_t          tag_q;
  data_t         rdata_q;
  resp_t         rresp_q;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state     <= IDLE;
      o_arvalid <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (i_valid) begin
            state     <= ADDR;
            o_arvalid <= 1'b1;
          end
        end
        ADDR: begin
          if (i_arready) begin // arvalid is high throughout addr.
            state     <= RESP;
            o_arvalid <= 1'b0;
          end
        end
        RESP: begin
          if (i_rvalid) begin
            state <= SEND;
          end
        end
        SEND: begin
          if (i_resp_ready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && i_valid) begin
      addr_q  <= i_addr;
      src_x_q <= i_src_x;
      src_y_q <= i_src_y;
      tag_q   <= i_tag;
    end
    if (state == RESP && i_rvalid) begin // r handshake cycle.
      rdata_q <= i_rdata;
      rresp_q <= i_rresp;
    end
  end

  assign o_ready  = (state == IDLE);
  assign o_rready = (state == RESP);
  assign o_araddr = addr_q;

  assign o_resp_valid = (state == SEND);
  assign o_resp_dst_x = src_x_q;
  assign o_resp_dst_y = src_y_q;
  assign o_resp_src_x = i_id_x;
  assign o_resp_src_y = i_id_y;
  assign o_resp_tag   = tag_q;
  assign o_resp_code  = rresp_q;
  assign o_resp_data  = rdata_q;

endmodule

//--- verilog/noc_axi_write_engine.sv
`timescale 1ns/1ns

module noc_axi_write_engine
  import noc_axi_pkg::*;
(
  input  logic  clk,
  input  logic  i_rst_n,
  input  id_x_t i_id_x,
  input  id_y_t i_id_y,
  input  logic  i_valid,
  output logic  o_ready,
  input  id_x_t i_src_x,
  input  id_y_t i_src_y,
  input  tag_t  i_tag,
  input  addr_t i_addr,
  input  data_t i_data,
  output logic  o_awvalid,
  input  logic  i_awready,
  output addr_t o_awaddr,
  output logic  o_wvalid,
  input  logic  i_wready,
  output data_t o_wdata,
  output strb_t o_wstrb,
  input  logic  i_bvalid,
  output logic  o_bready,
  input  resp_t i_bresp,
  output logic  o_resp_valid,
  input  logic  i_resp_ready,
  output id_x_t o_resp_dst_x,
  output id_y_t o_resp_dst_y,
  output id_x_t o_resp_src_x,
  output id_y_t o_resp_src_y,
  output tag_t  o_resp_tag,
  output resp_t o_resp_code
);

  engine_state_e state;
  addr_t         addr_q;
  data_t         data_q;
  id_x_t         src_x_q;
  id_y_t         src_y_q;
  tag_t          tag_q;
  resp_t         bresp_q;
  logic          aw_left; // aw still pending after this cycle.
  logic          w_left;  // w still pending after this cycle.

  // aw and w may complete in either order.
  assign aw_left = o_awvalid && !i_awready;
  assign w_left  = o_wvalid && !i_wready;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state     <= IDLE;
      o_awvalid <= 1'b0;
      o_wvalid  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (i_valid) begin
            state     <= ADDR;
            o_awvalid <= 1'b1;
            o_wvalid  <= 1'b1;
          end
        end
        ADDR: begin
          o_awvalid <= aw_left;
          o_wvalid  <= w_left;
          if (!aw_left && !w_left) begin
            state <= RESP;
          end
        end
        RESP: begin
          if (i_bvalid) begin
            state <= SEND;
          end
        end
        SEND: begin
          if (i_resp_ready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && i_valid) begin
      addr_q  <= i_addr;
      data_q  <= i_data;
      src_x_q <= i_src_x;
      src_y_q <= i_src_y;
      tag_q   <= i_tag;
    end
    if (state == RESP && i_bvalid) begin
      bresp_q <= i_bresp;
    end
  end

  assign o_ready  = (state == IDLE);
  assign o_bready = (state == RESP);
  assign o_awaddr = addr_q;
  assign o_wdata  = data_q;
  assign o_wstrb  = '1; // full-word writes only.

  assign o_resp_valid = (state == SEND);
  assign o_resp_dst_x = src_x_q; // back to the requester.
  assign o_resp_dst_y = src_y_q;
  assign o_resp_src_x = i_id_x;
  assign o_resp_src_y = i_id_y;
  assign o_resp_tag   = tag_q;
  assign o_resp_code  = bresp_q;

endmodule

//--- verilog/noc_flit_demux.sv
`timescale 1ns/1ns

module noc_flit_demux
  import noc_axi_pkg::*;
(
  input  logic      i_req_valid,
  output logic      o_req_ready,
  input  pkt_type_t i_req_type,
  input  logic      i_wr_ready,
  input  logic      i_rd_ready,
  output logic      o_wr_valid,
  output logic      o_rd_valid
);

  logic is_write;
  logic is_read;

  assign is_write = (i_req_type == PKT_WRITE);
  assign is_read  = (i_req_type == PKT_READ);

  assign o_wr_valid = i_req_valid && is_write;
  assign o_rd_valid = i_req_valid && is_read;

  // unknown and response types are swallowed here.
  always_comb begin
    case (i_req_type)
      PKT_WRITE: o_req_ready = i_wr_ready;
      PKT_READ:  o_req_ready = i_rd_ready;
      default:   o_req_ready = 1'b1; // drain without forwarding.
    endcase
  end

endmodule

//--- verilog/noc_resp_arbiter.sv
`timescale 1ns/1ns

module noc_resp_arbiter
  import noc_axi_pkg::*;
#(
  parameter bit ARB_ROUND_ROBIN = 1'b0
)(
  input  logic      clk,
  input  logic      i_rst_n,
  input  logic      i_wr_valid,
  output logic      o_wr_ready,
  input  id_x_t     i_wr_dst_x,
  input  id_y_t     i_wr_dst_y,
  input  id_x_t     i_wr_src_x,
  input  id_y_t     i_wr_src_y,
  input  tag_t      i_wr_tag,
  input  resp_t     i_wr_resp,
  input  logic      i_rd_valid,
  output logic      o_rd_ready,
  input  id_x_t     i_rd_dst_x,
  input  id_y_t     i_rd_dst_y,
  input  id_x_t     i_rd_src_x,
  input  id_y_t     i_rd_src_y,
  input  tag_t      i_rd_tag,
  input  resp_t     i_rd_resp,
  input  data_t     i_rd_data,
  output logic      o_flit_valid,
  input  logic      i_flit_ready,
  output pkt_type_t o_flit_type,
  output id_x_t     o_flit_src_x,
  output id_y_t     o_flit_src_y,
  output id_x_t     o_flit_dst_x,
  output id_y_t     o_flit_dst_y,
  output tag_t      o_flit_tag,
  output data_t     o_flit_data,
  output logic [RESP_W-1:0] o_flit_resp
);

  logic grant_valid;
  logic grant_rd; // 1 selects the read engine.
  logic last_rd;  // previous winner, round robin only.
  logic pick_rd;
  logic xfer;

  always_comb begin
    if (i_wr_valid && i_rd_valid) begin
      pick_rd = ARB_ROUND_ROBIN ? !last_rd : 1'b0; // fixed mode favors writes.
    end else begin
      pick_rd = i_rd_valid;
    end
  end

  assign xfer = o_flit_valid && i_flit_ready;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      grant_valid <= 1'b0;
      grant_rd    <= 1'b0;
      last_rd     <= 1'b0;
    end else if (!grant_valid) begin
      if (i_wr_valid || i_rd_valid) begin
        grant_valid <= 1'b1;
        grant_rd    <= pick_rd;
      end
    end else if (xfer) begin
      grant_valid <= 1'b0;
      last_rd     <= grant_rd;
    end
  end

  assign o_wr_ready = grant_valid && !grant_rd && i_flit_ready;
  assign o_rd_ready = grant_valid && grant_rd && i_flit_ready;

  // output follows the granted engine.
  assign o_flit_valid = grant_valid && (grant_rd ? i_rd_valid : i_wr_valid);
  assign o_flit_type  = grant_rd ? PKT_READ_RESP : PKT_WRITE_RESP;
  assign o_flit_src_x = grant_rd ? i_rd_src_x : i_wr_src_x;
  assign o_flit_src_y = grant_rd ? i_rd_src_y : i_wr_src_y;
  assign o_flit_dst_x = grant_rd ? i_rd_dst_x : i_wr_dst_x;
  assign o_flit_dst_y = grant_rd ? i_rd_dst_y : i_wr_dst_y;
  assign o_flit_tag   = grant_rd ? i_rd_tag : i_wr_tag;
  assign o_flit_data  = grant_rd ? i_rd_data : '0; // writes carry no data.
  assign o_flit_resp  = grant_rd ? i_rd_resp : i_wr_resp;

endmodule
